//--- verilog/arb_consts.svh
// Arbiter constants
`ifndef ARB_CONSTS_SVH
`define ARB_CONSTS_SVH

// Number of requesters
`define ARB_NUM_REQ 4

// Index and mode select widths
`define ARB_IDX_W   2
`define ARB_MODE_W  3

// Scheme select codes
`define ARB_MODE_P0   3'd0   // Requester 0 on top
`define ARB_MODE_P1   3'd1   // Requester 1 on top
`define ARB_MODE_P2   3'd2   // Requester 2 on top
`define ARB_MODE_P3   3'd3   // Requester 3 on top
`define ARB_MODE_RR   3'd4   // Round robin
`define ARB_MODE_RAND 3'd5   // LFSR picks the top requester

// Codes 6 and 7 are reserved and give no grant

// LFSR width
`define ARB_PN_W 3

// LFSR reset state with the first stage in bit 0
`define ARB_PN_RESET 3'b001

`endif

//--- verilog/arb_pkg.sv
// Arbiter vector types
`include "arb_consts.svh"

package arb_pkg;

  // One bit per requester
  typedef logic [`ARB_NUM_REQ-1:0] req_vec_t;

  // One-hot or zero
  typedef logic [`ARB_NUM_REQ-1:0] gnt_vec_t;

  // Scheme select
  typedef logic [`ARB_MODE_W-1:0] arb_mode_t;

  // Requester index
  // Used for the top priority slot, the LFSR index and the round robin pointer
  typedef logic [`ARB_IDX_W-1:0] port_idx_t;

endpackage

//--- verilog/pn_seq_gen.sv
// Pseudo-random priority index
`timescale 1ns/10ps
`include "arb_consts.svh"

module pn_seq_gen (
  input  logic               clk,
  input  logic               rst_n,
  output arb_pkg::port_idx_t rand_idx
);

  import arb_pkg::*;

  logic [`ARB_PN_W-1:0] pn_q;   // {s3, s2, s1}
  logic                 fb;

  // Taps on stages one and three give period seven
  assign fb = pn_q[0] ^ pn_q[2];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pn_q <= `ARB_PN_RESET;
    end else begin
      pn_q <= {pn_q[1], pn_q[0], fb};   // Shift toward s3
    end
  end

  // s3 high, s2 low
  assign rand_idx = port_idx_t'({pn_q[2], pn_q[1]});

  // All-zero state would lock up the sequence
  a_pn_nonzero: assert property (
    @(posedge clk) disable iff (!rst_n)
    pn_q != '0
  ) else $error("LFSR reached the all-zero state");

endmodule

//--- verilog/prio_pick.sv
// Fixed priority picker
`timescale 1ns/10ps
`include "arb_consts.svh"

module prio_pick (
  input  arb_pkg::req_vec_t  req,
  input  arb_pkg::port_idx_t top_idx,
  output arb_pkg::gnt_vec_t  pick
);

  import arb_pkg::*;

  gnt_vec_t top_pick;
  gnt_vec_t low_pick;

  // Top slot as a one-hot vector
  always_comb begin
    top_pick          = '0;
    top_pick[top_idx] = 1'b1;
  end

  // Lowest active requester wins the fallback
  always_comb begin
    low_pick = '0;
    for (int i = `ARB_NUM_REQ - 1; i >= 0; i--) begin
      if (req[i]) begin
        low_pick    = '0;
        low_pick[i] = 1'b1;
      end
    end
  end

  // Top requester first when it is active
  assign pick = req[top_idx] ? top_pick : low_pick;

endmodule

//--- verilog/rr_pick.sv
// Round robin picker
`timescale 1ns/10ps
`include "arb_consts.svh"

module rr_pick (
  input  logic              clk,
  input  logic              rst_n,
  input  arb_pkg::req_vec_t req,
  input  arb_pkg::gnt_vec_t gnt,
  output arb_pkg::gnt_vec_t pick
);

  import arb_pkg::*;

  port_idx_t ptr_q;     // Index of the last grant
  port_idx_t gnt_idx;
  port_idx_t base_idx;  // Last grant issued, current output included

  // Encode the registered grant
  always_comb begin
    gnt_idx = '0;
    for (int i = 0; i < `ARB_NUM_REQ; i++) begin
      if (gnt[i]) begin
        gnt_idx = port_idx_t'(i);
      end
    end
  end

  // Follows the grant in every mode
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ptr_q <= '0;
    end else if (|gnt) begin
      ptr_q <= gnt_idx;
    end
  end

  // A grant on the output counts before the register catches up
  assign base_idx = (|gnt) ? gnt_idx : ptr_q;

  // Cyclic search starting one past the pointer
  // Offset four wraps to the pointer itself and comes last
  always_comb begin
    port_idx_t cand;

    pick = '0;
    for (int k = `ARB_NUM_REQ; k >= 1; k--) begin
      cand = base_idx + port_idx_t'(k);
      if (req[cand]) begin
        pick       = '0;
        pick[cand] = 1'b1;
      end
    end
  end

  // Pointer holds through idle cycles
  a_ptr_hold: assert property (
    @(posedge clk) disable iff (!rst_n)
    (ptr_q != $past(ptr_q)) |-> $past(|gnt)
  ) else $error("Round robin pointer moved without a grant");

endmodule

//--- verilog/multi_arbiter.sv
// Four-way multi-scheme arbiter
`timescale 1ns/10ps
`include "arb_consts.svh"

module multi_arbiter (
  input  logic               clk,
  input  logic               rst_n,
  input  arb_pkg::req_vec_t  req,
  input  arb_pkg::arb_mode_t arb_mode,
  output arb_pkg::gnt_vec_t  gnt
);

  import arb_pkg::*;

  port_idx_t rand_idx;
  port_idx_t top_idx;
  gnt_vec_t  fixed_pick;
  gnt_vec_t  rr_pick;
  gnt_vec_t  gnt_d;
  logic      mode_valid;

  // Random index source, free running
  pn_seq_gen pn_seq_gen_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .rand_idx (rand_idx)
  );

  // Low mode bits name the top requester in fixed modes
  assign top_idx = (arb_mode == `ARB_MODE_RAND) ? rand_idx
                                                : port_idx_t'(arb_mode[1:0]);

  // Shared by fixed and random modes
  prio_pick prio_pick_i (
    .req     (req),
    .top_idx (top_idx),
    .pick    (fixed_pick)
  );

  rr_pick rr_pick_i (
    .clk   (clk),
    .rst_n (rst_n),
    .req   (req),
    .gnt   (gnt),
    .pick  (rr_pick)
  );

  assign mode_valid = (arb_mode <= `ARB_MODE_RAND);

  // Scheme select
  always_comb begin
    case (arb_mode)
      `ARB_MODE_P0,
      `ARB_MODE_P1,
      `ARB_MODE_P2,
      `ARB_MODE_P3,
      `ARB_MODE_RAND: gnt_d = fixed_pick;
      `ARB_MODE_RR:   gnt_d = rr_pick;
      default:        gnt_d = '0;   // Reserved
    endcase
  end

  // Registered grant
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      gnt <= '0;
    end else begin
      gnt <= gnt_d;
    end
  end

  // At most one winner
  a_gnt_onehot: assert property (
    @(posedge clk) disable iff (!rst_n)
    $onehot0(gnt)
  ) else $error("Grant is not one-hot or zero: %h", gnt);

  // No grant without a request one cycle earlier
  a_gnt_requested: assert property (
    @(posedge clk) disable iff (!rst_n)
    (gnt & ~$past(req)) == '0
  ) else $error("Grant %h to an idle requester", gnt);

  // Work conserving in every defined mode
  a_gnt_live: assert property (
    @(posedge clk) disable iff (!rst_n)
    ((|req) && mode_valid) |=> (|gnt)
  ) else $error("Requests pending but no grant");

  // Mode 0 never skips a lower index
  // gnt - 1 masks the bits below a one-hot grant
  a_mode0_order: assert property (
    @(posedge clk) disable iff (!rst_n)
    ((|gnt) && ($past(arb_mode) == `ARB_MODE_P0))
      |-> (($past(req) & (gnt - gnt_vec_t'(1))) == '0)
  ) else $error("Mode 0 grant %h passed over a lower requester", gnt);

endmodule

//--- sim/arb_checker.sv
// Arbiter grant checker
`timescale 1ns/10ps
`include "arb_consts.svh"

module arb_checker (
  input  logic               clk,
  input  logic               rst_n,
  input  arb_pkg::req_vec_t  req,
  input  arb_pkg::arb_mode_t arb_mode,
  input  arb_pkg::gnt_vec_t  gnt,
  input  logic               test_done,
  input  int                 test_id,
  input  logic               all_done,
  output int                 error_total,
  output logic               report_done
);

  import arb_pkg::*;

  logic            s1, s2, s3;      // Model LFSR stages
  port_idx_t       ptr_m;           // Model round robin pointer
  port_idx_t       ptr_now;         // Index of the last grant issued
  gnt_vec_t        exp_q;
  logic            rand_full_q;     // Random mode with all requests high
  gnt_vec_t [6:0]  hist;
  int              rand_run     = 0;
  int              test_checks  = 0;
  int              test_errors  = 0;
  int              tests_passed = 0;
  int              tests_failed = 0;
  int              errors_sum   = 0;
  logic            done_q       = 1'b0;

  assign error_total = errors_sum;
  assign report_done = done_q;

  // Top requester first, lowest index next; cyclic search for round robin
  function automatic gnt_vec_t expected_gnt(req_vec_t r, arb_mode_t m, port_idx_t ridx,
                                            port_idx_t p);
    gnt_vec_t  g;
    port_idx_t top;
    port_idx_t cand;
    logic      found;

    g     = '0;
    found = 1'b0;
    if (m == `ARB_MODE_RR) begin
      for (int k = 1; k <= `ARB_NUM_REQ; k++) begin
        cand = port_idx_t'((int'(p) + k) % `ARB_NUM_REQ);
        if (!found && r[cand]) begin
          g[cand] = 1'b1;
          found   = 1'b1;
        end
      end
    end else if (m <= `ARB_MODE_RAND) begin
      top = (m == `ARB_MODE_RAND) ? ridx : port_idx_t'(m[1:0]);
      if (r[top]) begin
        g[top] = 1'b1;
      end else begin
        for (int i = 0; i < `ARB_NUM_REQ; i++) begin
          if (!found && r[port_idx_t'(i)]) begin
            g[port_idx_t'(i)] = 1'b1;
            found             = 1'b1;
          end
        end
      end
    end
    return g;   // Reserved modes stay zero
  endfunction

  function automatic port_idx_t grant_index(gnt_vec_t g);
    port_idx_t idx;

    idx = '0;
    for (int i = 0; i < `ARB_NUM_REQ; i++) begin
      if (g[port_idx_t'(i)]) idx = port_idx_t'(i);
    end
    return idx;
  endfunction

  function automatic string test_name(int id);
    case (id)
      1:       return "reset";
      2:       return "fixed priority";
      3:       return "round robin fairness";
      4:       return "random priority";
      5:       return "reserved modes and mixed traffic";
      default: return "unknown";
    endcase
  endfunction

  // The grant on the output is the latest one, an idle output keeps the old pointer
  assign ptr_now = (|exp_q) ? grant_index(exp_q) : ptr_m;

  // Reference model state
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      {s3, s2, s1} <= `ARB_PN_RESET;
      ptr_m        <= '0;
      exp_q        <= '0;
      rand_full_q  <= 1'b0;
    end else begin
      exp_q       <= expected_gnt(req, arb_mode, port_idx_t'({s3, s2}), ptr_now);
      rand_full_q <= (arb_mode == `ARB_MODE_RAND) && (req == 4'hf);
      ptr_m       <= ptr_now;
      s1 <= s1 ^ s3;
      s2 <= s1;
      s3 <= s2;
    end
  end

  // Compare away from the rising edge
  always @(negedge clk) begin
    test_checks++;
    if (!rst_n) begin
      if (gnt !== '0) begin
        $display("Mismatch gnt in reset: expected 0x0, got 0x%h", gnt);
        test_errors++;
      end
    end else begin
      if (gnt !== exp_q) begin
        $display("Mismatch gnt at %0t: expected 0x%h, got 0x%h", $time, exp_q, gnt);
        test_errors++;
      end
      if (rand_full_q) begin
        if (rand_run >= 7) begin   // Period seven repeat
          test_checks++;
          if (gnt !== hist[6]) begin
            $display("Mismatch gnt period seven: expected 0x%h, got 0x%h", hist[6], gnt);
            test_errors++;
          end
        end
        hist = {hist[5:0], gnt};
        rand_run++;
      end else begin
        rand_run = 0;
      end
    end
    if (test_done) begin
      if (test_errors == 0) begin
        $display("Test %0d %s: ok, %0d checks", test_id, test_name(test_id), test_checks);
        tests_passed++;
      end else begin
        $display("Test %0d %s: %0d of %0d checks wrong", test_id, test_name(test_id),
                 test_errors, test_checks);
        tests_failed++;
      end
      errors_sum  += test_errors;
      test_checks = 0;
      test_errors = 0;
    end
    if (all_done && !done_q) begin
      errors_sum += test_errors;
      $display("Tests passed %0d, tests failed %0d, mismatches %0d",
               tests_passed, tests_failed, errors_sum);
      done_q = 1'b1;
    end
  end

endmodule

//--- sim/arb_tb.sv
// Multi-scheme arbiter testbench
`timescale 1ns/10ps
`include "arb_consts.svh"

module arb_tb;

  import arb_pkg::*;

  localparam int CLK_PERIOD    = 40;
  localparam int RESET_CYCLES  = 2;
  localparam int FINISH_CYCLES = 2;   // Drain plus the test end pulse
  localparam int RR_RUN        = 13;  // Ends off index 0 so the gap shows
  localparam int RR_GAP        = 3;
  localparam int RR_RESUME     = 9;
  localparam int RAND_RUN      = 28;
  localparam int RAND_PARTIAL  = 24;
  localparam int MIXED_CYCLES  = 400;
  localparam int TOTAL_CYCLES  = RESET_CYCLES + (2 + FINISH_CYCLES)
                               + (4 * 16 + FINISH_CYCLES)
                               + (1 + RR_RUN + RR_GAP + RR_RESUME + FINISH_CYCLES)
                               + (RAND_RUN + RAND_PARTIAL + FINISH_CYCLES)
                               + (2 * 16 + MIXED_CYCLES + FINISH_CYCLES) + 2;
  localparam int WATCHDOG_NS   = (TOTAL_CYCLES + 50) * CLK_PERIOD;

  logic      clk;
  logic      rst_n;
  req_vec_t  req;
  arb_mode_t arb_mode;
  gnt_vec_t  gnt;
  logic      test_done;
  logic      all_done;
  int        test_id;
  int        total_errors;
  logic      report_done;
  integer    seed;
  integer    rnd;

  initial begin
    clk       = 1'b0;
    rst_n     = 1'b0;
    req       = '0;
    arb_mode  = '0;
    test_done = 1'b0;
    all_done  = 1'b0;
    test_id   = 0;
    seed      = 23332;
  end

  always #(CLK_PERIOD / 2) clk = ~clk;

  multi_arbiter dut_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .req      (req),
    .arb_mode (arb_mode),
    .gnt      (gnt)
  );

  arb_checker checker_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .req          (req),
    .arb_mode     (arb_mode),
    .gnt          (gnt),
    .test_done    (test_done),
    .test_id      (test_id),
    .all_done     (all_done),
    .error_total  (total_errors),
    .report_done  (report_done)
  );

  // One request pattern for one cycle
  task automatic drive_cycle(input req_vec_t r, input arb_mode_t m);
    @(posedge clk);
    req      <= r;
    arb_mode <= m;
  endtask

  // Idle cycle, then the checker closes the test
  task automatic close_test(input int id);
    @(posedge clk);
    req       <= '0;
    test_id   <= id;
    test_done <= 1'b1;
    @(posedge clk);
    test_done <= 1'b0;
  endtask

  initial begin
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;

    // Reset, no requests
    repeat (2) drive_cycle('0, `ARB_MODE_P0);
    close_test(1);

    // Fixed priority, every pattern in modes 0 to 3
    for (int m = 0; m < 4; m++) begin
      for (int p = 0; p < 16; p++) begin
        drive_cycle(req_vec_t'(p), arb_mode_t'(m));
      end
    end
    close_test(2);

    // Grant to 0 first so the rotation starts at 1
    drive_cycle(4'b0001, `ARB_MODE_P0);
    repeat (RR_RUN) drive_cycle(4'hf, `ARB_MODE_RR);
    repeat (RR_GAP) drive_cycle(4'h0, `ARB_MODE_RR);   // Pointer must hold
    repeat (RR_RESUME) drive_cycle(4'hf, `ARB_MODE_RR);
    close_test(3);

    repeat (RAND_RUN) drive_cycle(4'hf, `ARB_MODE_RAND);
    repeat (RAND_PARTIAL) begin
      rnd = $random(seed);
      drive_cycle(req_vec_t'(rnd[3:0]), `ARB_MODE_RAND);
    end
    close_test(4);

    // Reserved modes, then mixed traffic
    for (int m = 6; m < 8; m++) begin
      for (int p = 0; p < 16; p++) begin
        drive_cycle(req_vec_t'(p), arb_mode_t'(m));
      end
    end
    repeat (MIXED_CYCLES) begin
      rnd = $random(seed);
      drive_cycle(req_vec_t'(rnd[3:0]), arb_mode_t'(rnd[6:4]));
    end
    close_test(5);

    @(posedge clk);
    all_done <= 1'b1;
    wait (report_done === 1'b1);
    if (total_errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired: the run did not finish within %0d cycles", TOTAL_CYCLES + 50);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

//--- sources.f
+incdir+verilog
verilog/arb_pkg.sv
verilog/pn_seq_gen.sv
verilog/prio_pick.sv
verilog/rr_pick.sv
verilog/multi_arbiter.sv
sim/arb_checker.sv
sim/arb_tb.sv

//--- Makefile
# Verilator build for the multi-scheme arbiter

VERILATOR  ?= verilator
TB_TOP     ?= arb_tb
RTL_TOP    ?= multi_arbiter
FILELIST   ?= sources.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
INC_DIRS   ?= -Iverilog
LINT_FLAGS ?= --lint-only -Wall
SIM_FLAGS  ?= --binary --timing --assert

RTL_SRCS   ?= verilog/arb_pkg.sv \
              verilog/pn_seq_gen.sv \
              verilog/prio_pick.sv \
              verilog/rr_pick.sv \
              verilog/multi_arbiter.sv

PASS_MSG   := TEST RESULT: PASS

.PHONY: all lint build sim clean

all: sim

# RTL only, with the design top
lint:
	$(VERILATOR) $(LINT_FLAGS) $(INC_DIRS) --top-module $(RTL_TOP) $(RTL_SRCS)

build:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		-Mdir $(BUILD_DIR) -o $(TB_TOP)

# Pass or fail comes from the log
sim: build
	-./$(BUILD_DIR)/$(TB_TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
